/* sources.f */
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_sequencer.sv
hdl/exec_core.sv
verification/exec_core_asserts.sv
verification/exec_core_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = exec_core_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# build and run, status comes from the search for the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)

/* verification/exec_core_tb.sv */
`timescale 1ns/10ps

module exec_core_tb;
  import isa_pkg::*;

  localparam int DONE_TIMEOUT = 100;  // cycles per command
  localparam int QUIET_CYCLES = 40;   // longer than a full mul/div

  logic        clk;
  logic        rst;
  logic        cmd_strobe;
  command_t    cmd;
  logic        busy;
  logic        done;
  alu_result_t result;
  logic        load_strobe;
  reg_idx_t    load_idx;
  data_t       load_data;
  reg_idx_t    peek_idx;
  data_t       peek_data;

  integer seed;
  int     errors;
  int     tests_passed;
  int     tests_failed;

  exec_core u_dut (
    .clk         (clk),
    .rst         (rst),
    .cmd_strobe  (cmd_strobe),
    .cmd         (cmd),
    .busy        (busy),
    .done        (done),
    .result      (result),
    .load_strobe (load_strobe),
    .load_idx    (load_idx),
    .load_data   (load_data),
    .peek_idx    (peek_idx),
    .peek_data   (peek_data)
  );

  always #5 clk = ~clk;  // 10 ns period

  function automatic data_t random_word();
    return data_t'($random(seed));
  endfunction

  // reference results straight from the operation rules
  function automatic alu_result_t expected_result(opcode_t op, data_t a, data_t b);
    alu_result_t r;
    logic [2*DATA_W-1:0] wide;
    r = '0;
    case (op)
      op_mov: r.lo = a;
      op_add: begin
        wide = {{DATA_W{1'b0}}, a} + {{DATA_W{1'b0}}, b};
        r    = alu_result_t'(wide);  // hi is the carry
      end
      op_sub: begin
        r.lo = a - b;
        r.hi = (a < b) ? '1 : '0;    // borrow word
      end
      op_mul: r = alu_result_t'({{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b});
      op_div: begin
        if (b == '0) begin
          r.lo = '1;
          r.hi = a;
        end else begin
          r.lo = a / b;
          r.hi = a % b;
        end
      end
      op_shr: r.lo = (b >= DATA_W) ? '0 : a >> b;
      op_shl: r.lo = (b >= DATA_W) ? '0 : a << b;
      op_xor: r.lo = a ^ b;
      op_and: r.lo = a & b;
      op_or:  r.lo = a | b;
      default: r = '0;  // codes 10..15
    endcase
    return r;
  endfunction

  function automatic command_t make_cmd(opcode_t op, reg_idx_t dst, reg_idx_t s0, reg_idx_t s1);
    command_t c;
    c.opcode = op;
    c.dst    = dst;
    c.src0   = s0;
    c.src1   = s1;
    c.spare  = 16'($random(seed));  // junk that must be ignored
    return c;
  endfunction

  task automatic check_result(input string name, input alu_result_t exp, input alu_result_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h_%h actual %h_%h", name, exp.hi, exp.lo, act.hi, act.lo);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic load_reg(input reg_idx_t idx, input data_t data);
    @(posedge clk);
    load_strobe <= 1'b1;
    load_idx    <= idx;
    load_data   <= data;
    @(posedge clk);  // written here
    load_strobe <= 1'b0;
  endtask

  task automatic peek_reg(input reg_idx_t idx, output data_t data);
    @(posedge clk);
    peek_idx <= idx;
    @(negedge clk);
    data = peek_data;
  endtask

  task automatic issue(input command_t c);
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd        <= c;
    @(posedge clk);  // accept edge if idle
    cmd_strobe <= 1'b0;
  endtask

  // cycles counted from the accept edge
  // busy has to stay high until done
  task automatic wait_done(input string name, output int cycles, output bit seen);
    bit busy_gap;
    seen     = 1'b0;
    busy_gap = 1'b0;
    cycles   = 0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (!busy) busy_gap = 1'b1;
      if (done) seen = 1'b1;
    end
    if (busy_gap) begin
      $display("%s: busy dropped before done", name);
      errors++;
    end
    if (!seen) begin
      $display("%s: timeout, no done within %0d cycles", name, DONE_TIMEOUT);
      errors++;
    end
  endtask

  // operands go in r1 and r2
  // dst preloaded with a value the result cannot have
  task automatic run_op(input string name, input opcode_t op, input data_t a, input data_t b,
                        input reg_idx_t dst, input int exp_cycles);
    alu_result_t exp;
    data_t       wb;
    int          cycles;
    bit          seen;
    exp = expected_result(op, a, b);
    load_reg(4'd1, a);
    load_reg(4'd2, b);
    load_reg(dst, ~exp.lo);
    issue(make_cmd(op, dst, 4'd1, 4'd2));
    wait_done(name, cycles, seen);
    if (seen) begin
      check_result(name, exp, result);
      if (exp_cycles > 0 && cycles != exp_cycles) begin
        $display("ERR %s latency expected %0d actual %0d", name, exp_cycles, cycles);
        errors++;
      end
      peek_reg(dst, wb);
      check_data({name, " writeback"}, exp.lo, wb);
    end
  endtask

  task automatic test_reset();
    int    err0;
    data_t v;
    err0 = errors;
    @(negedge clk);
    if (busy || done) begin
      $display("busy or done high right after reset");
      errors++;
    end
    check_result("reset result", '0, result);
    for (int i = 0; i < REG_COUNT; i++) begin
      peek_reg(reg_idx_t'(i), v);
      check_data("reset regs", '0, v);
    end
    report_test("reset", err0);
  endtask

  task automatic test_arith();
    int err0;
    err0 = errors;
    run_op("add", op_add, random_word(), random_word(), 4'd3, 4);
    run_op("add carry", op_add, 32'hffff_ffff, 32'h0000_0001, 4'd3, 4);
    run_op("sub", op_sub, random_word(), random_word(), 4'd3, 4);
    run_op("sub borrow", op_sub, 32'd5, 32'd9, 4'd3, 4);
    run_op("mov", op_mov, random_word(), random_word(), 4'd3, 4);
    run_op("xor", op_xor, random_word(), random_word(), 4'd3, 4);
    run_op("and", op_and, random_word(), random_word(), 4'd3, 4);
    run_op("or", op_or, random_word(), random_word(), 4'd3, 4);
    report_test("arith", err0);
  endtask

  task automatic test_shift();
    int    err0;
    data_t a;
    data_t amounts [5];
    err0 = errors;
    a = random_word();
    amounts[0] = 32'd0;
    amounts[1] = 32'd5;
    amounts[2] = 32'd31;
    amounts[3] = 32'd32;                          // first amount that clears
    amounts[4] = random_word() | 32'h8000_0000;   // large
    foreach (amounts[i]) begin
      run_op("shl", op_shl, a, amounts[i], 4'd3, 4);
      run_op("shr", op_shr, a, amounts[i], 4'd3, 4);
    end
    report_test("shift", err0);
  endtask

  task automatic test_muldiv();
    int err0;
    err0 = errors;
    run_op("mul", op_mul, random_word(), random_word(), 4'd3, 0);
    run_op("mul max", op_mul, 32'hffff_ffff, 32'hffff_ffff, 4'd3, 0);
    run_op("div", op_div, random_word(), random_word(), 4'd3, 0);
    run_op("div small", op_div, random_word(), random_word() & 32'h0000_00ff | 32'd1, 4'd3, 0);
    run_op("div zero", op_div, random_word(), 32'd0, 4'd3, 0);
    report_test("muldiv", err0);
  endtask

  task automatic test_busy();
    int          err0;
    int          cycles;
    int          extra;
    bit          seen;
    data_t       a;
    data_t       b;
    data_t       v;
    alu_result_t exp_mul;
    err0    = errors;
    a       = random_word();
    b       = random_word();
    exp_mul = expected_result(op_mul, a, b);
    load_reg(4'd4, a);
    load_reg(4'd5, b);
    load_reg(4'd9, 32'h9999_9999);
    load_reg(4'd10, 32'h1010_1010);
    issue(make_cmd(op_mul, 4'd8, 4'd4, 4'd5));
    repeat (2) @(posedge clk);
    issue(make_cmd(op_add, 4'd9, 4'd4, 4'd5));  // lands in the middle of the mul and is dropped
    wait_done("busy", cycles, seen);
    extra = 0;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (done) extra++;
    end
    if (extra != 0) begin
      $display("a strobe given while busy produced %0d more done pulses", extra);
      errors++;
    end
    peek_reg(4'd8, v);
    check_data("busy mul dst", exp_mul.lo, v);
    peek_reg(4'd9, v);
    check_data("busy dropped dst", 32'h9999_9999, v);
    peek_reg(4'd10, v);
    check_data("busy other reg", 32'h1010_1010, v);
    peek_reg(4'd4, v);
    check_data("busy src0", a, v);
    report_test("busy", err0);
  endtask

  task automatic test_undef();
    int err0;
    err0 = errors;
    run_op("undef", opcode_t'(4'd12), random_word(), random_word(), 4'd3, 4);
    report_test("undef", err0);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    cmd_strobe   = 1'b0;
    cmd          = '0;
    load_strobe  = 1'b0;
    load_idx     = '0;
    load_data    = '0;
    peek_idx     = '0;
    seed         = 72;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_arith();
    test_shift();
    test_muldiv();
    test_busy();
    test_undef();
    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verification/exec_core_asserts.sv */
`timescale 1ns/10ps

module exec_core_asserts (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic done
);

  // single-cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done held for more than one cycle");

  // done only at the end of a busy stretch
  a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy && $past(busy))
    else $error("done raised without busy high in that cycle and the one before");

  // back to idle right after the done cycle
  a_busy_drop: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
    else $error("busy still high in the cycle after done");

  a_reset_done: assert property (@(posedge clk) rst |=> !done)
    else $error("done high in the cycle after reset");

endmodule

bind exec_core exec_core_asserts u_asserts (
  .clk  (clk),
  .rst  (rst),
  .busy (busy),
  .done (done)
);

/* hdl/exec_core.sv */
`timescale 1ns/10ps

module exec_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_strobe,
  input  isa_pkg::command_t    cmd,
  output logic                 busy,
  output logic                 done,
  output isa_pkg::alu_result_t result,
  input  logic                 load_strobe,
  input  isa_pkg::reg_idx_t    load_idx,
  input  isa_pkg::data_t       load_data,
  input  isa_pkg::reg_idx_t    peek_idx,
  output isa_pkg::data_t       peek_data
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  seq_state_t    state;
  opcode_t       opcode;
  reg_idx_t      rd0_idx;
  reg_idx_t      rd1_idx;
  reg_idx_t      wr_idx;
  logic          wr_en;
  logic          alu_done;
  alu_operands_t operands;   // reg_file read ports to alu

  exec_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .alu_done   (alu_done),
    .state      (state),
    .opcode     (opcode),
    .rd0_idx    (rd0_idx),
    .rd1_idx    (rd1_idx),
    .wr_en      (wr_en),
    .wr_idx     (wr_idx),
    .busy       (busy),
    .done       (done)
  );

  reg_file u_regs (
    .clk         (clk),
    .rst         (rst),
    .rd0_idx     (rd0_idx),
    .rd1_idx     (rd1_idx),
    .operands    (operands),
    .wr_en       (wr_en),
    .wr_idx      (wr_idx),
    .wr_data     (result.lo),              // low half only
    .load_strobe (load_strobe && !busy),   // loads only while idle
    .load_idx    (load_idx),
    .load_data   (load_data),
    .peek_idx    (peek_idx),
    .peek_data   (peek_data)
  );

  alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .opcode   (opcode),
    .operands (operands),
    .result   (result),   // registered, held between commands
    .alu_done (alu_done)
  );

endmodule

/* hdl/exec_sequencer.sv */
`timescale 1ns/10ps

module exec_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_strobe,
  input  isa_pkg::command_t    cmd,
  input  logic                 alu_done,
  output ctrl_pkg::seq_state_t state,
  output isa_pkg::opcode_t     opcode,
  output isa_pkg::reg_idx_t    rd0_idx,
  output isa_pkg::reg_idx_t    rd1_idx,
  output logic                 wr_en,
  output isa_pkg::reg_idx_t    wr_idx,
  output logic                 busy,
  output logic                 done
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  command_t   cmd_q;        // command in flight
  logic       accept;
  seq_state_t state_next;

  // strobe while busy is simply dropped
  assign accept = cmd_strobe && (state == st_idle);

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (accept) begin
          state_next = st_operands;
        end
      end
      st_operands:  state_next = st_alu_begin;
      st_alu_begin: state_next = st_alu_wait;
      st_alu_wait: begin
        if (alu_done) begin   // variable latency for mul/div
          state_next = st_alu_results;
        end
      end
      st_alu_results: state_next = st_idle;
      default:        state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // everything below comes from the latched copy
  assign opcode  = cmd_q.opcode;
  assign rd0_idx = cmd_q.src0;
  assign rd1_idx = cmd_q.src1;
  assign wr_idx  = cmd_q.dst;

  assign wr_en = (state == st_alu_results);   // write at end of done cycle
  assign done  = (state == st_alu_results);
  assign busy  = (state != st_idle);

endmodule

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu (
  input  logic                   clk,
  input  logic                   rst,
  input  ctrl_pkg::seq_state_t   state,
  input  isa_pkg::opcode_t       opcode,
  input  isa_pkg::alu_operands_t operands,
  output isa_pkg::alu_result_t   result,
  output logic                   alu_done
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  data_t           a;
  data_t           b;
  logic [DATA_W:0] add_sum;      // carry in top bit
  logic [DATA_W:0] sub_diff;     // borrow in top bit
  logic            shift_over;   // amount >= DATA_W
  alu_result_t     quick;        // single-cycle result

  logic                iterative;
  logic                start;
  logic                running;
  logic                last_step;
  iter_cnt_t           cnt;
  logic [2*DATA_W-1:0] work;       // mul {acc, mplier}, div {rem, quo}
  logic [2*DATA_W-1:0] work_next;
  data_t               opnd;       // multiplicand or divisor
  logic [DATA_W:0]     mul_sum;
  logic [DATA_W:0]     div_shift;
  logic [DATA_W+1:0]   div_diff;   // extra bit for sign

  assign a = operands.src0;
  assign b = operands.src1;

  assign add_sum    = {1'b0, a} + {1'b0, b};
  assign sub_diff   = {1'b0, a} - {1'b0, b};
  assign shift_over = |b[DATA_W-1:SHAMT_W];

  always_comb begin
    quick = '0;   // undefined codes give zero
    case (opcode)
      op_mov: quick.lo = a;
      op_add: begin
        quick.lo = add_sum[DATA_W-1:0];
        quick.hi = data_t'(add_sum[DATA_W]);        // carry 0 or 1
      end
      op_sub: begin
        quick.lo = sub_diff[DATA_W-1:0];
        quick.hi = {DATA_W{sub_diff[DATA_W]}};      // all ones on borrow
      end
      op_shr: quick.lo = shift_over ? '0 : a >> b[SHAMT_W-1:0];
      op_shl: quick.lo = shift_over ? '0 : a << b[SHAMT_W-1:0];
      op_xor: quick.lo = a ^ b;
      op_and: quick.lo = a & b;
      op_or:  quick.lo = a | b;
      default: quick = '0;   // mul/div handled by the loop
    endcase
  end

  // mul and div go through the bit-serial loop
  assign iterative = (opcode == op_mul) || (opcode == op_div);
  assign start     = (state == st_alu_begin) && iterative;
  assign last_step = running && (cnt == iter_cnt_t'(1));

  // one bit per cycle
  always_comb begin
    // shift-add: add multiplicand into upper half when lsb set, then shift right
    mul_sum = {1'b0, work[2*DATA_W-1:DATA_W]} + (work[0] ? {1'b0, opnd} : '0);
    // restoring: bring next dividend bit into remainder, try subtract
    div_shift = {work[2*DATA_W-1:DATA_W], work[DATA_W-1]};
    div_diff  = {1'b0, div_shift} - {2'b0, opnd};
    if (opcode == op_mul) begin
      work_next = {mul_sum, work[DATA_W-1:1]};
    end else if (div_diff[DATA_W+1]) begin
      work_next = {div_shift[DATA_W-1:0], work[DATA_W-2:0], 1'b0};  // restore
    end else begin
      work_next = {div_diff[DATA_W-1:0], work[DATA_W-2:0], 1'b1};
    end
  end

  // loop datapath
  always_ff @(posedge clk) begin
    if (start) begin
      if (opcode == op_mul) begin
        work <= {{DATA_W{1'b0}}, b};   // multiplier in low half
        opnd <= a;
      end else begin
        work <= {{DATA_W{1'b0}}, a};   // dividend in low half
        opnd <= b;   // zero divisor ends as quo all ones, rem = a
      end
    end else if (running) begin
      work <= work_next;
    end
  end

  // result register and completion pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      cnt      <= '0;
      result   <= '0;
      alu_done <= 1'b0;
    end else begin
      alu_done <= 1'b0;   // pulse only
      if (state == st_alu_begin) begin
        if (iterative) begin
          running <= 1'b1;
          cnt     <= iter_cnt_t'(MULDIV_STEPS);
        end else begin
          result   <= quick;
          alu_done <= 1'b1;   // seen in st_alu_wait
        end
      end else if (running) begin
        cnt <= cnt - 1'b1;
        if (last_step) begin
          running   <= 1'b0;
          result.hi <= work_next[2*DATA_W-1:DATA_W];  // product hi / remainder
          result.lo <= work_next[DATA_W-1:0];         // product lo / quotient
          alu_done  <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  isa_pkg::reg_idx_t      rd0_idx,
  input  isa_pkg::reg_idx_t      rd1_idx,
  output isa_pkg::alu_operands_t operands,
  input  logic                   wr_en,
  input  isa_pkg::reg_idx_t      wr_idx,
  input  isa_pkg::data_t         wr_data,
  input  logic                   load_strobe,
  input  isa_pkg::reg_idx_t      load_idx,
  input  isa_pkg::data_t         load_data,
  input  isa_pkg::reg_idx_t      peek_idx,
  output isa_pkg::data_t         peek_data
);
  import isa_pkg::*;

  data_t regs [REG_COUNT];

  // writeback first, external load second
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;    // alu lo half
    end else if (load_strobe) begin
      regs[load_idx] <= load_data;
    end
  end

  // async read ports, packed the way the alu wants them
  assign operands.src0 = regs[rd0_idx];
  assign operands.src1 = regs[rd1_idx];

  assign peek_data = regs[peek_idx];  // debug / test visibility

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

  // steps of the shift-add / restoring loops, one bit each
  localparam int MULDIV_STEPS = 32;

  // sequencer states, one command in flight
  typedef enum logic [2:0] {
    st_idle,         // waiting for cmd_strobe
    st_operands,     // register indices settle
    st_alu_begin,    // alu samples operands
    st_alu_wait,     // held until alu_done
    st_alu_results   // done pulse and writeback
  } seq_state_t;

  // iteration counter, must hold MULDIV_STEPS itself
  typedef logic [5:0] iter_cnt_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

  localparam int DATA_W    = 32;                // operand and result word
  localparam int REG_COUNT = 16;                // register file depth
  localparam int IDX_W     = $clog2(REG_COUNT);
  localparam int SHAMT_W   = $clog2(DATA_W);    // low shift amount bits

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [IDX_W-1:0]  reg_idx_t;

  // 4-bit operation codes, 10..15 undefined
  typedef enum logic [3:0] {
    op_mov = 4'd0,
    op_add = 4'd1,
    op_sub = 4'd2,
    op_mul = 4'd3,
    op_div = 4'd4,
    op_shr = 4'd5,
    op_shl = 4'd6,
    op_xor = 4'd7,
    op_and = 4'd8,
    op_or  = 4'd9
  } opcode_t;

  // command word as it arrives on cmd
  typedef struct packed {
    opcode_t      opcode;  // 31:28
    reg_idx_t     dst;     // 27:24
    reg_idx_t     src0;    // 23:20
    reg_idx_t     src1;    // 19:16
    logic [15:0]  spare;   // ignored
  } command_t;

  typedef struct packed {
    data_t src0;
    data_t src1;
  } alu_operands_t;

  // hi on top so {hi, lo} reads as one 64-bit value
  typedef struct packed {
    data_t hi;
    data_t lo;
  } alu_result_t;

endpackage
